// ==== vlog.f ====
+incdir+verilog
verilog/execPkg.sv
verilog/execOpIf.sv
verilog/opQueue.sv
verilog/alu32.sv
verilog/execStage.sv
verilog/execUnit.sv
testbench/tb_execUnit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_execUnit
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module tb_execUnit;

    localparam int DEPTH   = `EXEC_QUEUE_DEPTH;
    localparam int TIMEOUT = 100;  // Cycles allowed per wait loop

    logic             clk;
    logic             rst;
    logic             opValid;
    execPkg::opCode_t opCode;
    execPkg::word_t   opA;
    execPkg::word_t   opB;
    execPkg::shamt_t  opShamt;
    logic             credit;
    logic             resValid;
    execPkg::word_t   resData;
    logic             resZero;
    logic             resWrite;

    execPkg::execOp_t expQ[$];    // Sent ops, oldest first
    string            nameQ[$];   // Test name per sent op
    execPkg::dword_t  modelHiLo;  // Reference HI/LO pair
    execPkg::opCode_t arithOps[10];
    execPkg::word_t   seVals[6];
    integer           seed;
    string            curTest;
    int credits, creditPulses, cycle, lastSendCycle;
    int errors, errStart, checks, testCount, pulsesStart, waitCycles;
    logic             timedOut;
    execPkg::execOp_t ckOp;
    string            ckName;
    execPkg::word_t   expData;
    logic             expWrite;
    execPkg::dword_t  expHiLo;
    execPkg::word_t   rnd;

    execUnit u_dut (
        .clk(clk), .rst(rst), .opValid(opValid), .opCode(opCode), .opA(opA), .opB(opB),
        .opShamt(opShamt), .credit(credit), .resValid(resValid), .resData(resData),
        .resZero(resZero), .resWrite(resWrite)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////
    // Reference model of one operation
    //////////////////////////////////////////////////////////////
    function automatic void refExec(input execPkg::execOp_t op, input execPkg::dword_t hlIn,
                                    output execPkg::word_t data, output logic wr,
                                    output execPkg::dword_t hlOut);
        execPkg::dword_t sProd;
        execPkg::word_t  b;
        int              n;
        b     = op.b;
        sProd = {{32{op.a[31]}}, op.a} * {{32{b[31]}}, b};  // Signed product mod 2^64
        data  = '0;
        wr    = 1'b1;
        hlOut = hlIn;
        n     = int'(op.shamt);
        if (op.code inside {execPkg::OP_SLLV, execPkg::OP_SRLV, execPkg::OP_SRAV,
                            execPkg::OP_ROTRV})
            n = int'(op.a[4:0]);  // Variable count from A
        case (op.code)
            execPkg::OP_ADD, execPkg::OP_ADDU: data = op.a + b;
            execPkg::OP_SUB:   data = op.a - b;
            execPkg::OP_MUL:   data = sProd[31:0];
            execPkg::OP_MULT: begin
                wr    = 1'b0;
                hlOut = sProd;
            end
            execPkg::OP_MULTU: begin
                wr    = 1'b0;
                hlOut = {32'b0, op.a} * {32'b0, b};
            end
            execPkg::OP_MADD: begin
                wr    = 1'b0;
                hlOut = hlIn + sProd;
            end
            execPkg::OP_MSUB: begin
                wr    = 1'b0;
                hlOut = hlIn - sProd;
            end
            execPkg::OP_AND:   data = op.a & b;
            execPkg::OP_OR:    data = op.a | b;
            execPkg::OP_NOR:   data = ~(op.a | b);
            execPkg::OP_XOR:   data = op.a ^ b;
            execPkg::OP_SLL,  execPkg::OP_SLLV:  data = b << n;
            execPkg::OP_SRL,  execPkg::OP_SRLV:  data = b >> n;
            execPkg::OP_SRA,  execPkg::OP_SRAV:
                data = (b >> n) | (~(32'hffff_ffff >> n) & {32{b[31]}});  // Sign fill
            execPkg::OP_ROTR, execPkg::OP_ROTRV: data = (b >> n) | (b << ((32 - n) % 32));
            execPkg::OP_SLT:   data = ($signed(op.a) < $signed(b)) ? 32'd1 : 32'd0;
            execPkg::OP_SLTU:  data = (op.a < b) ? 32'd1 : 32'd0;
            execPkg::OP_MOVN: begin
                wr   = (b != 0);
                data = wr ? op.a : '0;
            end
            execPkg::OP_MOVZ: begin
                wr   = (b == 0);
                data = wr ? op.a : '0;
            end
            execPkg::OP_SEB:   data = {{24{b[7]}}, b[7:0]};
            execPkg::OP_SEH:   data = {{16{b[15]}}, b[15:0]};
            execPkg::OP_MFHI:  data = hlIn[63:32];
            execPkg::OP_MFLO:  data = hlIn[31:0];
            default:           wr = 1'b0;
        endcase
    endfunction

    // Result checker and credit counter, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (credit) begin
                credits++;
                creditPulses++;
            end
            if (credit !== resValid) begin
                $display("credit pulse not aligned with a result in test %s", curTest);
                errors++;
            end
            if (resValid && expQ.size() == 0) begin
                $display("result arrived with no operation outstanding");
                errors++;
            end else if (resValid) begin
                ckOp   = expQ.pop_front();
                ckName = nameQ.pop_front();
                refExec(ckOp, modelHiLo, expData, expWrite, expHiLo);
                modelHiLo = expHiLo;
                checks++;
                if (resData !== expData) begin
                    $display("ERR %s %s data expected %h actual %h", ckName, ckOp.code.name(),
                             expData, resData);
                    errors++;
                end
                if (resZero !== (expData == 0)) begin
                    $display("ERR %s zero expected %b actual %b", ckName, expData == 0, resZero);
                    errors++;
                end
                if (resWrite !== expWrite) begin
                    $display("ERR %s write expected %b actual %b", ckName, expWrite, resWrite);
                    errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Producer side
    //////////////////////////////////////////////////////////////
    task automatic sendOp(input execPkg::opCode_t code, input execPkg::word_t a,
                          input execPkg::word_t b, input execPkg::shamt_t sh);
        waitCycles = 0;
        while (!timedOut && credits == 0) begin  // Hold off until a credit comes back
            @(posedge clk);
            #1;
            waitCycles++;
            if (waitCycles > TIMEOUT) begin
                $display("timeout: no credit returned within %0d cycles", TIMEOUT);
                timedOut = 1'b1;
            end
        end
        if (!timedOut) begin
            opValid = 1'b1;
            opCode  = code;
            opA     = a;
            opB     = b;
            opShamt = sh;
            credits--;
            expQ.push_back('{code: code, a: a, b: b, shamt: sh});
            nameQ.push_back(curTest);
            lastSendCycle = cycle;
            @(posedge clk);
            #1;
            opValid = 1'b0;
        end
    endtask

    task automatic waitDrain();
        waitCycles = 0;
        while (!timedOut && expQ.size() != 0) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > TIMEOUT) begin
                $display("timeout: %0d results never arrived", expQ.size());
                timedOut = 1'b1;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic startTest(input string name);
        curTest  = name;
        errStart = errors;
    endtask

    task automatic endTest();
        waitDrain();
        testCount++;
        $display("%-10s finished, %0d errors", curTest, errors - errStart);
    endtask

    initial begin
        rst          = 1'b1;
        opValid      = 1'b0;
        opCode       = execPkg::OP_ADD;
        opA          = '0;
        opB          = '0;
        opShamt      = '0;
        seed         = 32'h99c3_bba6;
        credits      = DEPTH;
        creditPulses = 0;
        cycle        = 0;
        modelHiLo    = '0;
        timedOut     = 1'b0;
        errors       = 0;
        checks       = 0;
        testCount    = 0;
        arithOps = '{execPkg::OP_ADD, execPkg::OP_ADDU, execPkg::OP_SUB, execPkg::OP_MUL,
                     execPkg::OP_AND, execPkg::OP_OR, execPkg::OP_NOR, execPkg::OP_XOR,
                     execPkg::OP_SLT, execPkg::OP_SLTU};
        seVals = '{32'h0000_0080, 32'h1234_567f, 32'hffff_8000, 32'h0000_7fff,
                   32'hdead_beef, 32'h0000_0000};
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        startTest("reset");
        repeat (6) begin  // Idle outputs with no traffic
            @(negedge clk);
            if (resValid !== 1'b0 || resWrite !== 1'b0 || credit !== 1'b0) begin
                $display("reset: outputs went active with no input");
                errors++;
            end
        end
        endTest();

        startTest("arith");
        foreach (arithOps[i]) begin  // Sign boundaries then random
            sendOp(arithOps[i], 32'h7fff_ffff, 32'h0000_0001, 5'd0);
            sendOp(arithOps[i], 32'h8000_0000, 32'hffff_ffff, 5'd0);
            sendOp(arithOps[i], 32'h8000_0000, 32'h7fff_ffff, 5'd0);
            sendOp(arithOps[i], 32'h0000_0000, 32'h0000_0000, 5'd0);
            repeat (6) sendOp(arithOps[i], $random(seed), $random(seed), 5'd0);
        end
        endTest();

        startTest("shift");
        for (int s = 0; s < 32; s++) begin
            rnd = $random(seed);
            sendOp(execPkg::OP_SLL, 32'h0, rnd, 5'(s));
            sendOp(execPkg::OP_SRL, 32'h0, rnd, 5'(s));
            sendOp(execPkg::OP_SRA, 32'h0, rnd | 32'h8000_0000, 5'(s));
            sendOp(execPkg::OP_ROTR, 32'h0, rnd, 5'(s));
            rnd = {rnd[31:5], 5'(s)};  // Count in A, shamt field ignored
            sendOp(execPkg::OP_SLLV, rnd, $random(seed), 5'(~s));
            sendOp(execPkg::OP_SRLV, rnd, $random(seed), 5'(~s));
            sendOp(execPkg::OP_SRAV, rnd, $random(seed), 5'(~s));
            sendOp(execPkg::OP_ROTRV, rnd, $random(seed), 5'(~s));
        end
        foreach (seVals[i]) begin
            sendOp(execPkg::OP_SEB, $random(seed), seVals[i], 5'd0);
            sendOp(execPkg::OP_SEH, $random(seed), seVals[i], 5'd0);
        end
        endTest();

        startTest("hilo");
        sendOp(execPkg::OP_MULT, 32'hffff_fffd, 32'd7, 5'd0);  // -3 * 7 signed
        sendOp(execPkg::OP_MFHI, 32'h0, 32'h0, 5'd0);
        sendOp(execPkg::OP_MFLO, 32'h0, 32'h0, 5'd0);
        sendOp(execPkg::OP_MULTU, 32'hffff_fffd, 32'd7, 5'd0);  // Same bits unsigned
        sendOp(execPkg::OP_MFHI, 32'h0, 32'h0, 5'd0);
        sendOp(execPkg::OP_MFLO, 32'h0, 32'h0, 5'd0);
        sendOp(execPkg::OP_MADD, 32'h1234_5678, 32'hffff_fffe, 5'd0);
        sendOp(execPkg::OP_MSUB, 32'h7fff_ffff, 32'h7fff_ffff, 5'd0);
        sendOp(execPkg::OP_MFHI, 32'h0, 32'h0, 5'd0);
        sendOp(execPkg::OP_MFLO, 32'h0, 32'h0, 5'd0);
        repeat (8) begin
            rnd = $random(seed);
            sendOp(rnd[0] ? execPkg::OP_MADD : execPkg::OP_MSUB, $random(seed),
                   $random(seed), 5'd0);
            sendOp(execPkg::OP_MFHI, 32'h0, 32'h0, 5'd0);
            sendOp(execPkg::OP_MFLO, 32'h0, 32'h0, 5'd0);
        end
        endTest();

        startTest("condMove");
        repeat (4) begin
            rnd = $random(seed);
            sendOp(execPkg::OP_MOVN, rnd, 32'h0, 5'd0);
            sendOp(execPkg::OP_MOVN, rnd, $random(seed) | 32'h1, 5'd0);
            sendOp(execPkg::OP_MOVZ, rnd, 32'h0, 5'd0);
            sendOp(execPkg::OP_MOVZ, rnd, 32'h8000_0000, 5'd0);
        end
        endTest();

        startTest("creditFlow");
        pulsesStart = creditPulses;
        repeat (12) sendOp(execPkg::opCode_t'(5'({$random(seed)} % 28)), $random(seed),
                           $random(seed), 5'($random(seed)));
        waitDrain();
        if (creditPulses - pulsesStart != 12 || credits != DEPTH) begin
            $display("ERR creditFlow credits expected %0d/%0d actual %0d/%0d", 12, DEPTH,
                     creditPulses - pulsesStart, credits);
            errors++;
        end
        sendOp(execPkg::OP_ADD, 32'd5, 32'd6, 5'd0);  // Lone op into an empty queue
        waitCycles = 0;
        while (!timedOut && !resValid) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > TIMEOUT) begin
                $display("timeout: lone operation never produced a result");
                timedOut = 1'b1;
            end
        end
        if (!timedOut && cycle - lastSendCycle != 2) begin
            $display("ERR creditFlow latency expected 2 actual %0d", cycle - lastSendCycle);
            errors++;
        end
        endTest();

        $display("tests %0d, results checked %0d, errors %0d", testCount, checks, errors);
        if (errors == 0 && !timedOut)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module execUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             opValid,   // Allowed only while holding a credit
    input  execPkg::opCode_t opCode,
    input  execPkg::word_t   opA,
    input  execPkg::word_t   opB,
    input  execPkg::shamt_t  opShamt,
    output logic             credit,
    output logic             resValid,
    output execPkg::word_t   resData,
    output logic             resZero,
    output logic             resWrite
);

    execPkg::execOp_t pushOp;
    execPkg::word_t   aluResult;
    logic             aluRegWrite;
    logic             aluHiLoWrite;
    execPkg::dword_t  aluHiLoNext;
    execPkg::dword_t  hiLo;

    execOpIf opBus ();  // Queue head to stage

    // Pack producer fields into a queue entry
    assign pushOp = '{code: opCode, a: opA, b: opB, shamt: opShamt};

    opQueue uQueue (
        .clk       (clk),
        .rst       (rst),
        .pushValid (opValid),
        .pushOp    (pushOp),
        .deq       (opBus.src),
        .credit    (credit)
    );

    alu32 uAlu (
        .op        (opBus.view),
        .hiLo      (hiLo),
        .result    (aluResult),
        .regWrite  (aluRegWrite),
        .hiLoWrite (aluHiLoWrite),
        .hiLoNext  (aluHiLoNext)
    );

    execStage uStage (
        .clk          (clk),
        .rst          (rst),
        .src          (opBus.dst),
        .aluResult    (aluResult),
        .aluRegWrite  (aluRegWrite),
        .aluHiLoWrite (aluHiLoWrite),
        .aluHiLoNext  (aluHiLoNext),
        .hiLo         (hiLo),
        .resValid     (resValid),
        .resData      (resData),
        .resZero      (resZero),
        .resWrite     (resWrite)
    );

endmodule

`default_nettype wire

// ==== verilog/execStage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module execStage (
    input  logic            clk,
    input  logic            rst,
    execOpIf.dst            src,
    input  execPkg::word_t  aluResult,
    input  logic            aluRegWrite,
    input  logic            aluHiLoWrite,
    input  execPkg::dword_t aluHiLoNext,
    output execPkg::dword_t hiLo,
    output logic            resValid,
    output execPkg::word_t  resData,
    output logic            resZero,
    output logic            resWrite
);

    // Never stalls, head is taken as soon as it shows up
    assign src.pop = src.valid;

    //////////////////////////////////////////////////////////////
    // HI/LO pair and result flags
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            hiLo     <= '0;
            resValid <= 1'b0;
            resWrite <= 1'b0;
        end else begin
            resValid <= src.pop;
            resWrite <= src.pop && aluRegWrite;  // Only for real results
            if (src.pop && aluHiLoWrite) begin
                hiLo <= aluHiLoNext;  // Next op sees the new pair
            end
        end
    end

    // Result word, loaded only when an op retires
    always_ff @(posedge clk) begin
        if (src.pop) begin
            resData <= aluResult;
        end
    end

    assign resZero = (resData == '0);  // Flag follows the registered word

    // Write flag without a valid result would corrupt the register file
    assert property (@(posedge clk) disable iff (rst) resWrite |-> resValid)
        else $error("execStage: resWrite without resValid");

endmodule

`default_nettype wire

// ==== verilog/alu32.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module alu32 (
    execOpIf.view           op,
    input  execPkg::dword_t hiLo,       // Current HI/LO pair
    output execPkg::word_t  result,
    output logic            regWrite,
    output logic            hiLoWrite,
    output execPkg::dword_t hiLoNext
);

    localparam int W = `EXEC_DATA_W;

    execPkg::word_t  a;
    execPkg::word_t  b;
    execPkg::shamt_t varAmt;             // Variable shift count from A
    logic signed [2*W-1:0] prodS;         // Signed full product
    execPkg::dword_t prodU;              // Unsigned full product

    assign a      = op.op.a;
    assign b      = op.op.b;
    assign varAmt = a[`EXEC_SHAMT_W-1:0];

    // Operands sign extended by assignment context
    assign prodS = $signed(a) * $signed(b);
    assign prodU = {{W{1'b0}}, a} * {{W{1'b0}}, b};

    // Rotate right via doubled word
    function automatic execPkg::word_t rotR(execPkg::word_t x, execPkg::shamt_t n);
        execPkg::dword_t both;
        both = {x, x} >> n;
        return both[W-1:0];
    endfunction

    //////////////////////////////////////////////////////////////
    // Operation decode
    //////////////////////////////////////////////////////////////
    always_comb begin
        result    = '0;     // Nothing for HI/LO-only ops
        regWrite  = 1'b1;   // Most ops write a register
        hiLoWrite = 1'b0;
        hiLoNext  = hiLo;   // Hold pair unless a multiply writes it

        case (op.op.code)
            // Arithmetic, all wrapping
            execPkg::OP_ADD,
            execPkg::OP_ADDU: result = a + b;
            execPkg::OP_SUB:  result = a - b;
            execPkg::OP_MUL:  result = prodS[W-1:0];  // Low word only

            // Multiplies into HI/LO
            execPkg::OP_MULT: begin
                regWrite  = 1'b0;
                hiLoWrite = 1'b1;
                hiLoNext  = prodS;
            end
            execPkg::OP_MULTU: begin
                regWrite  = 1'b0;
                hiLoWrite = 1'b1;
                hiLoNext  = prodU;
            end
            execPkg::OP_MADD: begin
                regWrite  = 1'b0;
                hiLoWrite = 1'b1;
                hiLoNext  = hiLo + prodS;  // Accumulate
            end
            execPkg::OP_MSUB: begin
                regWrite  = 1'b0;
                hiLoWrite = 1'b1;
                hiLoNext  = hiLo - prodS;
            end

            // Bitwise
            execPkg::OP_AND: result = a & b;
            execPkg::OP_OR:  result = a | b;
            execPkg::OP_NOR: result = ~(a | b);
            execPkg::OP_XOR: result = a ^ b;

            // Fixed shifts, count from instruction field
            execPkg::OP_SLL:  result = b << op.op.shamt;
            execPkg::OP_SRL:  result = b >> op.op.shamt;
            execPkg::OP_SRA:  result = $signed(b) >>> op.op.shamt;
            execPkg::OP_ROTR: result = rotR(b, op.op.shamt);

            // Variable shifts, count from A[4:0]
            execPkg::OP_SLLV:  result = b << varAmt;
            execPkg::OP_SRLV:  result = b >> varAmt;
            execPkg::OP_SRAV:  result = $signed(b) >>> varAmt;
            execPkg::OP_ROTRV: result = rotR(b, varAmt);

            // Set on less than
            execPkg::OP_SLT:  result = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            execPkg::OP_SLTU: result = {{(W-1){1'b0}}, a < b};

            // Conditional moves, no write when condition fails
            execPkg::OP_MOVN: begin
                regWrite = (b != '0);
                result   = regWrite ? a : '0;
            end
            execPkg::OP_MOVZ: begin
                regWrite = (b == '0);
                result   = regWrite ? a : '0;
            end

            // Sign extension of B
            execPkg::OP_SEB: result = {{(W-8){b[7]}}, b[7:0]};
            execPkg::OP_SEH: result = {{(W-16){b[15]}}, b[15:0]};

            // HI/LO readback
            execPkg::OP_MFHI: result = hiLo[2*W-1:W];
            execPkg::OP_MFLO: result = hiLo[W-1:0];

            default: regWrite = 1'b0;  // Unused encodings do nothing
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/opQueue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module opQueue (
    input  logic             clk,
    input  logic             rst,
    input  logic             pushValid,
    input  execPkg::execOp_t pushOp,
    execOpIf.src             deq,
    output logic             credit     // One pulse per entry freed
);

    localparam int DEPTH = `EXEC_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    execPkg::execOp_t mem [DEPTH];  // Entry storage
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;         // Occupied entries
    logic             full;

    assign full      = (count == CNT_W'(DEPTH));
    assign deq.valid = (count != '0);
    assign deq.op    = mem[rdPtr];   // Head is always at the read pointer

    //////////////////////////////////////////////////////////////
    // Storage write
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushOp;
        end
    end

    //////////////////////////////////////////////////////////////
    // Pointers, occupancy and credit return
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= deq.pop;  // Freed slot goes back to producer
            if (pushValid) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (deq.pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({pushValid, deq.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Producer must honor its credits
    assert property (@(posedge clk) disable iff (rst) !(pushValid && full))
        else $error("opQueue: push while full, credit count broken");

    // Stage may only consume what is there
    assert property (@(posedge clk) disable iff (rst) deq.pop |-> deq.valid)
        else $error("opQueue: pop while empty");

endmodule

`default_nettype wire

// ==== verilog/execOpIf.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

// Head of the operation queue as seen by the stage
interface execOpIf;
    logic            valid;  // Head entry present
    execPkg::execOp_t op;    // Head entry contents
    logic            pop;    // Consume head this cycle

    // Queue side
    modport src (output valid, output op, input pop);

    // Stage side
    modport dst (input valid, input op, output pop);

    // ALU only looks at the operation
    modport view (input op);
endinterface

`default_nettype wire

// ==== verilog/execPkg.sv ====
`default_nettype none

`include "exec_defines.svh"

package execPkg;

    // Operation codes, one per supported instruction
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_ADDU  = 5'd1,
        OP_SUB   = 5'd2,
        OP_MULT  = 5'd3,
        OP_MULTU = 5'd4,
        OP_AND   = 5'd5,
        OP_OR    = 5'd6,
        OP_NOR   = 5'd7,
        OP_XOR   = 5'd8,
        OP_SLL   = 5'd9,
        OP_SRL   = 5'd10,
        OP_SLLV  = 5'd11,
        OP_SLT   = 5'd12,
        OP_MOVN  = 5'd13,
        OP_MOVZ  = 5'd14,
        OP_ROTRV = 5'd15,
        OP_SRA   = 5'd16,
        OP_SRAV  = 5'd17,
        OP_SLTU  = 5'd18,
        OP_MUL   = 5'd19,
        OP_MADD  = 5'd20,
        OP_MSUB  = 5'd21,
        OP_SEH   = 5'd22,
        OP_SEB   = 5'd23,
        OP_ROTR  = 5'd24,
        OP_SRLV  = 5'd25,
        OP_MFHI  = 5'd26,
        OP_MFLO  = 5'd27
    } opCode_t;

    typedef logic [`EXEC_DATA_W-1:0]   word_t;   // Register-sized value
    typedef logic [2*`EXEC_DATA_W-1:0] dword_t;  // HI in upper half, LO in lower
    typedef logic [`EXEC_SHAMT_W-1:0]  shamt_t;

    // One queue entry
    typedef struct packed {
        opCode_t code;
        word_t   a;
        word_t   b;
        shamt_t  shamt;
    } execOp_t;

endpackage

`default_nettype wire

// ==== verilog/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

//////////////////////////////////////////////////////////////
// Execute stage sizing
//////////////////////////////////////////////////////////////

// Operand and result width
`define EXEC_DATA_W 32

// Shift amount field, enough for 0..31
`define EXEC_SHAMT_W 5

// Pending operation slots
// Producer starts out with this many credits
`define EXEC_QUEUE_DEPTH 4

`endif
